// File: common/scc_consts.svh
`ifndef SCC_CONSTS_SVH
`define SCC_CONSTS_SVH

// register pointer values
`define SCC_WR0           4'd0
`define SCC_WR1           4'd1
`define SCC_WR2           4'd2
`define SCC_WR9           4'd9
`define SCC_WR15          4'd15
`define SCC_RR0           4'd0
`define SCC_RR1           4'd1
`define SCC_RR2           4'd2
`define SCC_RR3           4'd3
`define SCC_RR15          4'd15

`define SCC_CMD_POINT_HIGH 3'b001 // wr0[5:3]
`define SCC_CMD_RESET_EXT  3'b010
`define SCC_RST_CHAN_A     2'b10  // wr9[7:6]
`define SCC_RST_CHAN_B     2'b01
`define SCC_RST_FULL       2'b11

`define SCC_WR15_RESET     8'hF8
`define SCC_RR0_FIXED      8'h44  // tx empty, tx underrun
`define SCC_RR1_FIXED      8'h07  // all sent, residue code

`define SCC_VEC_EXT_A      3'b101
`define SCC_VEC_EXT_B      3'b001
`define SCC_VEC_NONE       3'b011

`define SCC_WR1_EXT_IE     0
`define SCC_WR15_DCD_IE    3
`define SCC_WR9_MIE        3
`define SCC_WR9_VIS_HIGH   4

`endif

// File: common/scc_pkg.sv
`default_nettype none

package scc_pkg;

	// channel b vector word, status field placed per wr9 bit 4
	typedef union packed {
		struct packed {
			logic [3:0] hi;       // from wr2
			logic [2:0] stat;     // status in bits 3:1
			logic       lo;       // from wr2
		} st_low;
		struct packed {
			logic       hi;       // from wr2
			logic [2:0] stat_rev; // status in bits 6:4, bit order reversed
			logic [3:0] lo;       // from wr2
		} st_high;
	} rr2_vector_u;

	// both views cover the same 8 bits

endpackage

`default_nettype wire

// File: common/scc_chan_if.sv
`timescale 1ns/1ps
`default_nettype none

interface scc_chan_if;

	logic       wr_stb;     // register write to this channel
	logic       ext_reset;  // reset ext/status command
	logic       chan_reset; // channel or full reset
	logic       full_reset;
	logic [3:0] wr_index;   // pointer at time of write
	logic [7:0] wr_data;

	logic       dcd_status; // dcd as seen in rr0
	logic [7:0] rr15;
	logic       ex_pend;    // ext/status irq pending

	// bus decode drives strobes and write data
	modport bus (output wr_stb, ext_reset, chan_reset, full_reset, wr_index, wr_data);

	modport chan (
		input  wr_stb, ext_reset, chan_reset, full_reset, wr_index, wr_data,
		output dcd_status, rr15, ex_pend
	);

	// read side only sees status
	modport rd (input dcd_status, rr15, ex_pend);

endinterface

`default_nettype wire

// File: logic/reg_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "scc_consts.svh"

module reg_access (
	input  wire        clk,
	input  wire        reset_hw,
	input  wire        i_cs,
	input  wire        i_we,
	input  wire  [1:0] i_rs,    // [1] data/ctl, [0] a/b
	input  wire  [7:0] i_wdata,
	output logic [3:0] o_index,
	output logic [7:0] o_wr2,
	output logic [5:0] o_wr9,
	scc_chan_if.bus    chan_a,
	scc_chan_if.bus    chan_b
);

	logic [3:0] rindex; // register pointer
	logic       ctl_acc;
	logic       wreg;
	logic       wr0_wr;
	logic       wr9_wr;
	logic       ext_cmd;
	logic       rst_a;
	logic       rst_b;
	logic       rst_full;

	assign ctl_acc = i_cs & ~i_rs[1];  // control port, read or write
	assign wreg    = ctl_acc & i_we;
	assign wr0_wr  = wreg & (rindex == `SCC_WR0);
	assign wr9_wr  = wreg & (rindex == `SCC_WR9);
	assign ext_cmd = wr0_wr & (i_wdata[5:3] == `SCC_CMD_RESET_EXT);

	// wr9 reset codes, full reset also resets both channels
	assign rst_full = wr9_wr & (i_wdata[7:6] == `SCC_RST_FULL);
	assign rst_a    = (wr9_wr & (i_wdata[7:6] == `SCC_RST_CHAN_A)) | rst_full;
	assign rst_b    = (wr9_wr & (i_wdata[7:6] == `SCC_RST_CHAN_B)) | rst_full;

	// pointer back to 0 after any control access, except a wr0 write
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			rindex <= '0;
		end else if (ctl_acc) begin
			if (wr0_wr)
				rindex <= {i_wdata[5:3] == `SCC_CMD_POINT_HIGH, i_wdata[2:0]}; // point high adds 8
			else
				rindex <= '0;
		end
	end

	// wr2 and wr9 shared, side ignored
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			o_wr2 <= '0;
			o_wr9 <= '0;
		end else begin
			if (wreg && rindex == `SCC_WR2)
				o_wr2 <= i_wdata;
			if (wr9_wr)
				o_wr9 <= i_wdata[5:0]; // top bits are commands, not stored
		end
	end

	assign o_index = rindex;

	assign chan_a.wr_stb     = wreg & i_rs[0];
	assign chan_a.ext_reset  = ext_cmd & i_rs[0];
	assign chan_a.chan_reset = rst_a;
	assign chan_a.full_reset = rst_full;
	assign chan_a.wr_index   = rindex;
	assign chan_a.wr_data    = i_wdata;

	assign chan_b.wr_stb     = wreg & ~i_rs[0];
	assign chan_b.ext_reset  = ext_cmd & ~i_rs[0];
	assign chan_b.chan_reset = rst_b;
	assign chan_b.full_reset = rst_full;
	assign chan_b.wr_index   = rindex;
	assign chan_b.wr_data    = i_wdata;

endmodule

`default_nettype wire

// File: channel/scc_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "scc_consts.svh"

module scc_channel (
	input  wire      clk,
	input  wire      reset_hw,
	input  wire      i_dcd,    // not synchronized here
	scc_chan_if.chan chan_if
);

	logic [7:0] wr1;
	logic [7:0] wr15;
	logic       dcd_latch;
	logic       latch_open;
	logic       ex_pend;
	logic       wr1_wr;
	logic       wr15_wr;
	logic       dcd_ip;
	logic       do_latch;
	logic       reopen;

	assign wr1_wr  = chan_if.wr_stb & (chan_if.wr_index == `SCC_WR1);
	assign wr15_wr = chan_if.wr_stb & (chan_if.wr_index == `SCC_WR15);
	assign reopen  = chan_if.ext_reset | chan_if.full_reset;

	// change on an enabled source while latch is open
	assign dcd_ip   = (i_dcd != dcd_latch) & wr15[`SCC_WR15_DCD_IE];
	assign do_latch = latch_open & dcd_ip;

	// wr1, channel reset keeps bits 5 and 2
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			wr1 <= '0;
		else if (chan_if.chan_reset)
			wr1 <= {2'b00, wr1[5], 2'b00, wr1[2], 2'b00};
		else if (wr1_wr)
			wr1 <= chan_if.wr_data;
	end

	// wr15 only returns to its default on full or hw reset
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			wr15 <= `SCC_WR15_RESET;
		else if (chan_if.full_reset)
			wr15 <= `SCC_WR15_RESET;
		else if (wr15_wr)
			wr15 <= chan_if.wr_data;
	end

	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw) begin
			latch_open <= 1'b1;
			dcd_latch  <= 1'b0;
		end else if (reopen) begin
			latch_open <= 1'b1;
			dcd_latch  <= i_dcd;  // reopen at current level
		end else if (do_latch) begin
			latch_open <= 1'b0;   // hold until ext reset
			dcd_latch  <= i_dcd;
		end
	end

	// pending set when latch closes with ext ie in wr1
	always_ff @(posedge clk or posedge reset_hw) begin
		if (reset_hw)
			ex_pend <= 1'b0;
		else if (reopen)
			ex_pend <= 1'b0;
		else if (do_latch && wr1[`SCC_WR1_EXT_IE])
			ex_pend <= 1'b1;
	end

	// latched dcd only when its ie is on
	assign chan_if.dcd_status = wr15[`SCC_WR15_DCD_IE] ? dcd_latch : i_dcd;
	assign chan_if.rr15       = {wr15[7:3], 1'b0, wr15[1], 1'b0}; // bits 2,0 read 0
	assign chan_if.ex_pend    = ex_pend;

endmodule

`default_nettype wire

// File: logic/read_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "scc_consts.svh"

module read_mux import scc_pkg::*; (
	input  wire  [1:0] i_rs,
	input  wire  [3:0] i_index,
	input  wire  [7:0] i_wr2,
	input  wire  [5:0] i_wr9,
	output logic [7:0] o_rdata,
	output logic       o_irq_n,
	scc_chan_if.rd     chan_a,
	scc_chan_if.rd     chan_b
);

	logic [7:0]  rr0_a;
	logic [7:0]  rr0_b;
	logic [7:0]  rr3_a;
	logic [2:0]  vec_stat;
	rr2_vector_u rr2_b;
	logic        side_a;

	assign side_a = i_rs[0];

	// dcd sits in bit 3
	assign rr0_a = `SCC_RR0_FIXED | {4'b0000, chan_a.dcd_status, 3'b000};
	assign rr0_b = `SCC_RR0_FIXED | {4'b0000, chan_b.dcd_status, 3'b000};

	assign rr3_a = {4'b0000, chan_a.ex_pend, 2'b00, chan_b.ex_pend}; // a in bit 3, b in bit 0

	// channel a wins
	assign vec_stat = chan_a.ex_pend ? `SCC_VEC_EXT_A :
	                  chan_b.ex_pend ? `SCC_VEC_EXT_B : `SCC_VEC_NONE;

	// status includes vector, position picked by wr9 bit 4
	always_comb begin
		rr2_b = i_wr2;
		if (i_wr9[`SCC_WR9_VIS_HIGH])
			rr2_b.st_high.stat_rev = {vec_stat[0], vec_stat[1], vec_stat[2]};
		else
			rr2_b.st_low.stat = vec_stat;
	end

	always_comb begin
		o_rdata = 8'h00;  // data port and unused indices
		if (!i_rs[1]) begin
			case (i_index)
				`SCC_RR0, 4'd4:   o_rdata = side_a ? rr0_a : rr0_b;
				`SCC_RR1, 4'd5:   o_rdata = `SCC_RR1_FIXED;
				`SCC_RR2, 4'd6:   o_rdata = side_a ? i_wr2 : rr2_b; // a side reads raw wr2
				`SCC_RR3, 4'd7:   o_rdata = side_a ? rr3_a : 8'h00; // rr3 on a only
				`SCC_RR15, 4'd11: o_rdata = side_a ? chan_a.rr15 : chan_b.rr15;
				default:          o_rdata = 8'h00;
			endcase
		end
	end

	// master enable gates both channels
	assign o_irq_n = ~(i_wr9[`SCC_WR9_MIE] & (chan_a.ex_pend | chan_b.ex_pend));

endmodule

`default_nettype wire

// File: logic/scc_top.sv
`timescale 1ns/1ps
`default_nettype none

module scc_top (
	input  wire        clk,
	input  wire        reset_hw,
	input  wire        i_cs,
	input  wire        i_we,
	input  wire  [1:0] i_rs,
	input  wire  [7:0] i_wdata,
	input  wire        i_dcd_a,
	input  wire        i_dcd_b,
	output logic [7:0] o_rdata,
	output logic       o_irq_n
);

	logic [3:0] index;
	logic [7:0] wr2;
	logic [5:0] wr9;  // low bits only

	scc_chan_if if_a ();
	scc_chan_if if_b ();

	reg_access u_reg_access (
		.clk      (clk),
		.reset_hw (reset_hw),
		.i_cs     (i_cs),
		.i_we     (i_we),
		.i_rs     (i_rs),
		.i_wdata  (i_wdata),
		.o_index  (index),
		.o_wr2    (wr2),
		.o_wr9    (wr9),
		.chan_a   (if_a.bus),
		.chan_b   (if_b.bus)
	);

	scc_channel chan_a (.clk(clk), .reset_hw(reset_hw), .i_dcd(i_dcd_a), .chan_if(if_a.chan));
	scc_channel chan_b (.clk(clk), .reset_hw(reset_hw), .i_dcd(i_dcd_b), .chan_if(if_b.chan));

	// read path is combinational, same cycle as access
	read_mux u_read_mux (
		.i_rs    (i_rs),
		.i_index (index),
		.i_wr2   (wr2),
		.i_wr9   (wr9),
		.o_rdata (o_rdata),
		.o_irq_n (o_irq_n),
		.chan_a  (if_a.rd),
		.chan_b  (if_b.rd)
	);

endmodule

`default_nettype wire

// File: test/scc_tests.svh
// values straight out of hw reset
task automatic test_reset_state();
	logic [7:0] rd;
	ctl_read(SIDE_A, 4'd15, rd);
	check_value("rr15 a after reset", rd, 8'hF8);
	ctl_read(SIDE_B, 4'd15, rd);
	check_value("rr15 b after reset", rd, 8'hF8);
	ctl_read(SIDE_A, 4'd0, rd);
	check_value("rr0 a after reset", rd, rr0_value(1'b0));
	ctl_read(SIDE_A, 4'd3, rd);
	check_value("rr3 after reset", rd, 8'h00);
	data_read(SIDE_A, rd); // no data path
	check_value("data port read", rd, 8'h00);
	check_value("irq_n after reset", {7'b0, o_irq_n}, 8'h01);
endtask

task automatic test_pointer();
	logic [7:0] rd;
	ctl_write(SIDE_A, 4'd2, 8'h5A);
	ctl_read(SIDE_A, 4'd2, rd);
	check_value("rr2 a reads wr2", rd, 8'h5A);
	bus_cycle(1'b0, {1'b0, SIDE_A}, 8'h00, rd); // pointer back at 0
	check_value("control read without pointer", rd, rr0_value(1'b0));
	ctl_write(SIDE_B, 4'd15, 8'hAF); // point high plus 7
	ctl_read(SIDE_B, 4'd15, rd);
	check_value("rr15 b", rd, rr15_value(8'hAF));
	ctl_read(SIDE_B, 4'd11, rd);
	check_value("rr15 b mirror at 11", rd, rr15_value(8'hAF));
endtask

task automatic test_ext_status();
	logic [7:0] rd;
	ctl_write(SIDE_A, 4'd15, 8'h08); // dcd ie only
	ctl_write(SIDE_A, 4'd1, 8'h01);  // ext/status ie
	ctl_write(SIDE_A, 4'd9, 8'h08);  // master enable
	i_dcd_a = 1'b1;
	wait_irq_low(2);
	check_value("irq_n after dcd a rise", {7'b0, o_irq_n}, 8'h00);
	ctl_read(SIDE_A, 4'd3, rd);
	check_value("rr3 a pending", rd, 8'h08);
	i_dcd_a = 1'b0;
	ctl_read(SIDE_A, 4'd0, rd); // latch still holds the 1
	check_value("rr0 a latched dcd", rd, rr0_value(1'b1));
	ctl_write(SIDE_A, 4'd0, 8'h10); // reset ext/status
	check_value("irq_n after ext reset", {7'b0, o_irq_n}, 8'h01);
	ctl_read(SIDE_A, 4'd0, rd);
	check_value("rr0 a live dcd", rd, rr0_value(i_dcd_a));
endtask

// status codes placed into the channel b vector
task automatic test_vector();
	logic [7:0] rd;
	ctl_write(SIDE_A, 4'd2, 8'h3C);
	i_dcd_a = 1'b1; // a pending
	wait_irq_low(2);
	ctl_read(SIDE_B, 4'd2, rd);
	check_value("rr2 b status low, ext a", rd, vec_low(8'h3C, 3'b101));
	ctl_read(SIDE_A, 4'd2, rd);
	check_value("rr2 a raw wr2", rd, 8'h3C);
	ctl_write(SIDE_A, 4'd9, 8'h18); // vis high
	ctl_read(SIDE_B, 4'd2, rd);
	check_value("rr2 b status high, ext a", rd, vec_high(8'h3C, 3'b101));
	ctl_write(SIDE_A, 4'd0, 8'h10); // a clears, latch reopens at 1
	ctl_write(SIDE_B, 4'd1, 8'h01);
	i_dcd_b = 1'b1;
	wait_irq_low(2);
	ctl_read(SIDE_A, 4'd3, rd);
	check_value("rr3 b pending", rd, 8'h01);
	ctl_read(SIDE_B, 4'd2, rd);
	check_value("rr2 b status high, ext b", rd, vec_high(8'h3C, 3'b001));
	ctl_write(SIDE_B, 4'd0, 8'h10);
	ctl_read(SIDE_B, 4'd2, rd);
	check_value("rr2 b status high, none", rd, vec_high(8'h3C, 3'b011));
	ctl_write(SIDE_A, 4'd9, 8'h08);
endtask

task automatic test_resets();
	logic [7:0] rd;
	ctl_write(SIDE_A, 4'd9, 8'h88); // chan a reset, mie kept
	i_dcd_a = 1'b0;
	repeat (2) @(posedge clk);
	#1;
	check_value("irq_n after chan a reset", {7'b0, o_irq_n}, 8'h01);
	i_dcd_a = 1'b1; // latch closed at 0
	ctl_read(SIDE_A, 4'd0, rd);
	check_value("rr0 a held after close", rd, rr0_value(1'b0));
	i_dcd_b = 1'b0; // b still enabled
	wait_irq_low(2);
	check_value("irq_n with b pending", {7'b0, o_irq_n}, 8'h00);
	ctl_write(SIDE_B, 4'd9, 8'hC8); // full reset
	check_value("irq_n after full reset", {7'b0, o_irq_n}, 8'h01);
	ctl_read(SIDE_A, 4'd3, rd);
	check_value("rr3 after full reset", rd, 8'h00);
	ctl_read(SIDE_A, 4'd15, rd);
	check_value("rr15 a after full reset", rd, 8'hF8);
	ctl_read(SIDE_B, 4'd15, rd);
	check_value("rr15 b after full reset", rd, 8'hF8);
endtask

// File: test/tb_scc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_scc;

	localparam int CLK_PERIOD     = 8;
	localparam int RESET_CYCLES   = 8;
	localparam int TIMEOUT_CYCLES = 2000; // tests take under 100 cycles
	localparam logic SIDE_A       = 1'b1;
	localparam logic SIDE_B       = 1'b0;

	logic       clk;
	logic       reset_hw;
	logic       i_cs;
	logic       i_we;
	logic [1:0] i_rs;
	logic [7:0] i_wdata;
	logic       i_dcd_a;
	logic       i_dcd_b;
	wire  [7:0] o_rdata;
	wire        o_irq_n;
	int         err_count   = 0;
	int         cycle_count = 0;

	scc_top dut (
		.clk(clk), .reset_hw(reset_hw), .i_cs(i_cs), .i_we(i_we), .i_rs(i_rs),
		.i_wdata(i_wdata), .i_dcd_a(i_dcd_a), .i_dcd_b(i_dcd_b),
		.o_rdata(o_rdata), .o_irq_n(o_irq_n)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Done: errors found");
		$fatal(1);
	end

	// expected words built from the register map
	function automatic logic [7:0] rr0_value(input logic dcd);
		return dcd ? 8'h4C : 8'h44; // tx empty and underrun, dcd adds bit 3
	endfunction

	function automatic logic [7:0] rr15_value(input logic [7:0] wr15);
		return wr15 & 8'hFA; // bits 2 and 0 read back 0
	endfunction

	function automatic logic [7:0] vec_low(input logic [7:0] wr2, input logic [2:0] code);
		return {wr2[7:4], code, wr2[0]};
	endfunction

	function automatic logic [7:0] vec_high(input logic [7:0] wr2, input logic [2:0] code);
		return {wr2[7], code[0], code[1], code[2], wr2[3:0]}; // reversed in 6:4
	endfunction

	task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	// one access cycle entered 1 ns after an edge
	task automatic bus_cycle(input logic we, input logic [1:0] rs, input logic [7:0] wdata,
		output logic [7:0] rdata);
		i_cs    = 1'b1;
		i_we    = we;
		i_rs    = rs;
		i_wdata = wdata;
		#5;
		rdata = o_rdata; // comb read settled well before the edge
		@(posedge clk);
		#1;
		i_cs    = 1'b0;
		i_we    = 1'b0;
		i_wdata = 8'h00;
	endtask

	task automatic set_pointer(input logic side, input logic [3:0] idx);
		logic [7:0] dummy;
		if (idx != 4'd0) // index 0 needs no wr0 write
			bus_cycle(1'b1, {1'b0, side}, {2'b00, idx[3] ? 3'b001 : 3'b000, idx[2:0]}, dummy);
	endtask

	task automatic ctl_write(input logic side, input logic [3:0] idx, input logic [7:0] data);
		logic [7:0] dummy;
		set_pointer(side, idx);
		bus_cycle(1'b1, {1'b0, side}, data, dummy);
	endtask

	task automatic ctl_read(input logic side, input logic [3:0] idx, output logic [7:0] data);
		set_pointer(side, idx);
		bus_cycle(1'b0, {1'b0, side}, 8'h00, data);
	endtask

	task automatic data_read(input logic side, output logic [7:0] data);
		bus_cycle(1'b0, {1'b1, side}, 8'h00, data);
	endtask

	// bounded wait until irq goes low
	task automatic wait_irq_low(input int max_cycles);
		int n;
		n = 0;
		while (o_irq_n && n < max_cycles) begin
			@(posedge clk);
			#1;
			n++;
		end
	endtask

	`include "scc_tests.svh"

	initial begin
		reset_hw = 1'b1;
		i_cs     = 1'b0;
		i_we     = 1'b0;
		i_rs     = 2'b00;
		i_wdata  = 8'h00;
		i_dcd_a  = 1'b0;
		i_dcd_b  = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset_hw = 1'b0;
		test_reset_state();
		test_pointer();
		test_ext_status();
		test_vector();
		test_resets();
		if (err_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
+incdir+test
common/scc_pkg.sv
common/scc_chan_if.sv
logic/reg_access.sv
channel/scc_channel.sv
logic/read_mux.sv
logic/scc_top.sv
test/tb_scc.sv

// File: Makefile
TOP := tb_scc

all: run

run:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f verilog.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) 2>&1 | tee sim.log
	@! grep -q "Done: errors found" sim.log
	@grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module scc_top -f verilog.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
